//--- files.f
+incdir+source
source/mips_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/mem_arbiter.sv
source/mips_top.sv
bench/mips_tb.sv

//--- Makefile
TOP = mips_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f files.f --Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- bench/mips_tb.sv
`include "mips_settings.svh"

module mips_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// isa opcodes
	localparam logic [5:0] opc_special = 6'h00;
	localparam logic [5:0] opc_j = 6'h02;
	localparam logic [5:0] opc_beq = 6'h04;
	localparam logic [5:0] opc_addi = 6'h08;
	localparam logic [5:0] opc_lw = 6'h23;
	localparam logic [5:0] opc_sw = 6'h2b;
	localparam logic [5:0] opc_halt = 6'h3f;
	// r-type functions
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;
	// all zero word is sll of r0 into r0
	localparam logic [`MIPS_WORD_BITS-1:0] nop_word = '0;

	localparam int num_tests = 5;
	localparam int max_words = 16;
	localparam int max_checks = 12;
	localparam int halt_timeout = 500;
	localparam int half_period = 20;

	// one expected register or memory word
	typedef struct packed {
		logic is_mem;
		logic [`MIPS_MEM_ADDR_BITS-1:0] addr;
		logic [`MIPS_WORD_BITS-1:0] value;
	} check_t;

	logic clk;
	logic arst_n;
	logic load_en;
	logic load_we;
	logic [`MIPS_MEM_ADDR_BITS-1:0] load_addr;
	logic [`MIPS_WORD_BITS-1:0] load_data;
	logic [`MIPS_WORD_BITS-1:0] load_rdata;
	logic [`MIPS_REG_ADDR_BITS-1:0] dbg_reg_addr;
	logic [`MIPS_WORD_BITS-1:0] dbg_reg_data;
	logic halted;

	// program table
	string test_name [num_tests];
	logic [`MIPS_WORD_BITS-1:0] prog [num_tests][max_words];
	int prog_len [num_tests];
	check_t checks [num_tests][max_checks];
	int check_count [num_tests];

	mips_top i_dut (
		.clk(clk),
		.arst_n(arst_n),
		.load_en(load_en),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data),
		.load_rdata(load_rdata),
		.dbg_reg_addr(dbg_reg_addr),
		.dbg_reg_data(dbg_reg_data),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	//////////////////////////////
	// instruction encoding
	//////////////////////////////

	function automatic logic [`MIPS_WORD_BITS-1:0] r_type_word(input logic [5:0] funct,
		input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
		return {opc_special, rs, rt, rd, 5'd0, funct};
	endfunction

	// rt is the destination or the store source
	function automatic logic [`MIPS_WORD_BITS-1:0] i_type_word(input logic [5:0] op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// word address target
	function automatic logic [`MIPS_WORD_BITS-1:0] jump_word(input logic [25:0] target);
		return {opc_j, target};
	endfunction

	function automatic logic [`MIPS_WORD_BITS-1:0] halt_word();
		return {opc_halt, 26'd0};
	endfunction

	//////////////////////////////
	// table helpers
	//////////////////////////////

	task automatic put_word(input int t, input logic [`MIPS_WORD_BITS-1:0] word);
		prog[t][prog_len[t]] = word;
		prog_len[t]++;
	endtask

	task automatic expect_reg(input int t, input logic [4:0] idx,
		input logic [`MIPS_WORD_BITS-1:0] value);
		checks[t][check_count[t]] = '{is_mem: 1'b0, addr: {3'b000, idx}, value: value};
		check_count[t]++;
	endtask

	task automatic expect_mem(input int t, input logic [`MIPS_MEM_ADDR_BITS-1:0] addr,
		input logic [`MIPS_WORD_BITS-1:0] value);
		checks[t][check_count[t]] = '{is_mem: 1'b1, addr: addr, value: value};
		check_count[t]++;
	endtask

	task automatic build_table();
		for (int t = 0; t < num_tests; t++) begin
			prog_len[t] = 0;
			check_count[t] = 0;
		end
		// addi and r-type ops with a signed slt and an r0 write
		test_name[0] = "arithmetic";
		put_word(0, i_type_word(opc_addi, 5'd0, 5'd1, 16'd7));
		put_word(0, i_type_word(opc_addi, 5'd0, 5'd2, 16'hfffd));
		put_word(0, nop_word);
		put_word(0, r_type_word(fn_addu, 5'd3, 5'd1, 5'd2));
		put_word(0, r_type_word(fn_subu, 5'd4, 5'd1, 5'd2));
		put_word(0, r_type_word(fn_and, 5'd5, 5'd1, 5'd2));
		put_word(0, r_type_word(fn_or, 5'd6, 5'd1, 5'd2));
		put_word(0, r_type_word(fn_slt, 5'd7, 5'd2, 5'd1));
		put_word(0, r_type_word(fn_slt, 5'd8, 5'd1, 5'd2));
		put_word(0, i_type_word(opc_addi, 5'd0, 5'd0, 16'd5));
		put_word(0, i_type_word(opc_addi, 5'd3, 5'd9, 16'd100));
		put_word(0, halt_word());
		expect_reg(0, 5'd1, 32'h0000_0007);
		expect_reg(0, 5'd2, 32'hffff_fffd);
		expect_reg(0, 5'd3, 32'h0000_0004);
		expect_reg(0, 5'd4, 32'h0000_000a);
		expect_reg(0, 5'd5, 32'h0000_0005);
		expect_reg(0, 5'd6, 32'hffff_ffff);
		expect_reg(0, 5'd7, 32'h0000_0001);
		expect_reg(0, 5'd8, 32'h0000_0000);
		expect_reg(0, 5'd0, 32'h0000_0000);
		expect_reg(0, 5'd9, 32'h0000_0068);
		// store and load back and store a sum
		// offsets count words
		test_name[1] = "memory";
		put_word(1, i_type_word(opc_addi, 5'd0, 5'd1, 16'h1234));
		put_word(1, i_type_word(opc_addi, 5'd0, 5'd2, 16'd40));
		put_word(1, nop_word);
		put_word(1, i_type_word(opc_sw, 5'd2, 5'd1, 16'd0));
		put_word(1, i_type_word(opc_lw, 5'd2, 5'd3, 16'd0));
		put_word(1, nop_word);
		put_word(1, r_type_word(fn_addu, 5'd4, 5'd3, 5'd1));
		put_word(1, nop_word);
		put_word(1, i_type_word(opc_sw, 5'd2, 5'd4, 16'd1));
		put_word(1, halt_word());
		expect_reg(1, 5'd3, 32'h0000_1234);
		expect_reg(1, 5'd4, 32'h0000_2468);
		expect_mem(1, 8'd40, 32'h0000_1234);
		expect_mem(1, 8'd41, 32'h0000_2468);
		// taken beq at 5 lands on the writer at 8
		test_name[2] = "branch";
		put_word(2, i_type_word(opc_addi, 5'd0, 5'd1, 16'd5));
		put_word(2, i_type_word(opc_addi, 5'd0, 5'd2, 16'd5));
		put_word(2, i_type_word(opc_addi, 5'd0, 5'd3, 16'd6));
		put_word(2, i_type_word(opc_addi, 5'd0, 5'd4, 16'h0011));
		put_word(2, i_type_word(opc_addi, 5'd0, 5'd5, 16'h0022));
		put_word(2, i_type_word(opc_beq, 5'd1, 5'd2, 16'd2));
		put_word(2, i_type_word(opc_addi, 5'd0, 5'd4, 16'h0099));
		put_word(2, i_type_word(opc_addi, 5'd0, 5'd5, 16'h0099));
		put_word(2, i_type_word(opc_addi, 5'd0, 5'd6, 16'd9));
		// not-taken beq at 9 would skip the writer at 10
		put_word(2, i_type_word(opc_beq, 5'd1, 5'd3, 16'd1));
		put_word(2, i_type_word(opc_addi, 5'd0, 5'd7, 16'd8));
		put_word(2, halt_word());
		expect_reg(2, 5'd4, 32'h0000_0011);
		expect_reg(2, 5'd5, 32'h0000_0022);
		expect_reg(2, 5'd6, 32'h0000_0009);
		expect_reg(2, 5'd7, 32'h0000_0008);
		// j from 3 over three writers to 7
		test_name[3] = "jump";
		put_word(3, i_type_word(opc_addi, 5'd0, 5'd8, 16'h0033));
		put_word(3, i_type_word(opc_addi, 5'd0, 5'd9, 16'h0044));
		put_word(3, i_type_word(opc_addi, 5'd0, 5'd10, 16'h0066));
		put_word(3, jump_word(26'd7));
		put_word(3, i_type_word(opc_addi, 5'd0, 5'd8, 16'd1));
		put_word(3, i_type_word(opc_addi, 5'd0, 5'd9, 16'd2));
		put_word(3, i_type_word(opc_addi, 5'd0, 5'd10, 16'd3));
		put_word(3, i_type_word(opc_addi, 5'd0, 5'd11, 16'h0055));
		put_word(3, halt_word());
		expect_reg(3, 5'd8, 32'h0000_0033);
		expect_reg(3, 5'd9, 32'h0000_0044);
		expect_reg(3, 5'd10, 32'h0000_0066);
		expect_reg(3, 5'd11, 32'h0000_0055);
		// code past the halt must stay silent
		test_name[4] = "halt_reload";
		put_word(4, i_type_word(opc_addi, 5'd0, 5'd12, 16'h0077));
		put_word(4, i_type_word(opc_addi, 5'd0, 5'd13, 16'h0012));
		put_word(4, halt_word());
		put_word(4, i_type_word(opc_addi, 5'd0, 5'd12, 16'h0088));
		put_word(4, i_type_word(opc_addi, 5'd0, 5'd13, 16'h0099));
		put_word(4, i_type_word(opc_sw, 5'd0, 5'd12, 16'd60));
		put_word(4, halt_word());
		expect_reg(4, 5'd12, 32'h0000_0077);
		expect_reg(4, 5'd13, 32'h0000_0012);
		expect_mem(4, 8'd60, 32'h0000_0000);
	endtask

	//////////////////////////////
	// checks and run control
	//////////////////////////////

	task automatic check_value(input string label, input logic [`MIPS_WORD_BITS-1:0] expected,
		input logic [`MIPS_WORD_BITS-1:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s: expected %h, actual %h", label, expected, actual);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// program words first and zeros up to the top of memory
	task automatic load_program(input int t);
		@(negedge clk);
		load_en = 1'b1;
		load_we = 1'b1;
		for (int a = 0; a < `MIPS_MEM_WORDS; a++) begin
			load_addr = a[`MIPS_MEM_ADDR_BITS-1:0];
			load_data = (a < prog_len[t]) ? prog[t][a] : '0;
			@(negedge clk);
		end
		load_we = 1'b0;
		// halt level dropped while loading
		check_value({test_name[t], " halted clear"}, '0, {31'b0, halted});
		load_en = 1'b0;
	endtask

	task automatic wait_halt(input int t);
		int cycles;
		cycles = 0;
		while (!halted && cycles < halt_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("program %s did not halt within %0d cycles", test_name[t], halt_timeout);
			$display("test failed");
			$fatal(1, "halt timeout");
		end
	endtask

	// drive the address and sample one cycle later
	task automatic check_results(input int t);
		check_t entry;
		for (int i = 0; i < check_count[t]; i++) begin
			entry = checks[t][i];
			@(negedge clk);
			if (entry.is_mem) begin
				load_addr = entry.addr;
				@(negedge clk);
				check_value($sformatf("%s mem[%0d]", test_name[t], entry.addr),
					entry.value, load_rdata);
			end else begin
				dbg_reg_addr = entry.addr[`MIPS_REG_ADDR_BITS-1:0];
				@(negedge clk);
				check_value($sformatf("%s r%0d", test_name[t], entry.addr),
					entry.value, dbg_reg_data);
			end
		end
	endtask

	initial begin
		// loader owns the memory during reset
		arst_n = 1'b0;
		load_en = 1'b1;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		dbg_reg_addr = '0;
		build_table();
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		for (int t = 0; t < num_tests; t++) begin
			load_program(t);
			wait_halt(t);
			check_results(t);
		end
		$display("test passed");
		$finish;
	end

endmodule

//--- source/mips_top.sv
`include "mips_settings.svh"

module mips_top (
	input logic clk,
	input logic arst_n,
	input logic load_en,
	input logic load_we,
	input logic [`MIPS_MEM_ADDR_BITS-1:0] load_addr,
	input logic [`MIPS_WORD_BITS-1:0] load_data,
	output logic [`MIPS_WORD_BITS-1:0] load_rdata,
	input logic [`MIPS_REG_ADDR_BITS-1:0] dbg_reg_addr,
	output logic [`MIPS_WORD_BITS-1:0] dbg_reg_data,
	output logic halted
);
	import mips_pkg::*;

	// memory side
	mem_req_t fetch_req;
	mem_req_t data_req;
	logic fetch_gnt;
	logic data_gnt;
	logic [`MIPS_WORD_BITS-1:0] rdata;

	// pipeline links
	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	wb_t wb;

	// control flow change out of execute
	logic redirect;
	logic [`MIPS_MEM_ADDR_BITS-1:0] redirect_pc;

	//////////////////////////////
	// pipeline stages
	//////////////////////////////

	fetch_stage u_fetch (
		.clk(clk),
		.arst_n(arst_n),
		.load_en(load_en),
		.halted(halted),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.fetch_req(fetch_req),
		.fetch_gnt(fetch_gnt),
		.fetch_word(rdata),
		.if_id(if_id)
	);

	// redirect doubles as the flush of the two younger stages
	decode_stage u_decode (
		.clk(clk),
		.arst_n(arst_n),
		.load_en(load_en),
		.halted(halted),
		.flush(redirect),
		.if_id(if_id),
		.wb(wb),
		.dbg_reg_addr(dbg_reg_addr),
		.dbg_reg_data(dbg_reg_data),
		.id_ex(id_ex)
	);

	execute_stage u_execute (
		.clk(clk),
		.arst_n(arst_n),
		.load_en(load_en),
		.halted(halted),
		.id_ex(id_ex),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.ex_mem(ex_mem)
	);

	memory_stage u_memory (
		.clk(clk),
		.arst_n(arst_n),
		.load_en(load_en),
		.ex_mem(ex_mem),
		.data_req(data_req),
		.data_gnt(data_gnt),
		.data_word(rdata),
		.wb(wb),
		.halted(halted)
	);

	//////////////////////////////
	// shared memory
	//////////////////////////////

	mem_arbiter u_arbiter (
		.clk(clk),
		.arst_n(arst_n),
		.load_en(load_en),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data),
		.load_rdata(load_rdata),
		.fetch_req(fetch_req),
		.fetch_gnt(fetch_gnt),
		.data_req(data_req),
		.data_gnt(data_gnt),
		.rdata(rdata)
	);

endmodule

//--- source/mem_arbiter.sv
`include "mips_settings.svh"

module mem_arbiter (
	input logic clk,
	input logic arst_n,
	input logic load_en,
	input logic load_we,
	input logic [`MIPS_MEM_ADDR_BITS-1:0] load_addr,
	input logic [`MIPS_WORD_BITS-1:0] load_data,
	output logic [`MIPS_WORD_BITS-1:0] load_rdata,
	input mips_pkg::mem_req_t fetch_req,
	output logic fetch_gnt,
	input mips_pkg::mem_req_t data_req,
	output logic data_gnt,
	output logic [`MIPS_WORD_BITS-1:0] rdata
);
	import mips_pkg::*;

	logic run_q;
	grant_e grant;
	logic [`MIPS_MEM_ADDR_BITS-1:0] mem_addr;
	logic mem_we;
	logic [`MIPS_WORD_BITS-1:0] mem_wdata;
	logic [`MIPS_WORD_BITS-1:0] mem [`MIPS_MEM_WORDS];

	// pipeline requests honoured from the first edge after reset release
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			run_q <= 1'b0;
		else
			run_q <= 1'b1;
	end

	//////////////////////////////
	// fixed priority grant
	//////////////////////////////

	// loader, then data, then fetch
	always_comb begin
		if (load_en)
			grant = gnt_load;
		else if (run_q && data_req.valid)
			grant = gnt_data;
		else if (run_q && fetch_req.valid)
			grant = gnt_fetch;
		else
			grant = gnt_none;
	end

	assign fetch_gnt = (grant == gnt_fetch);
	assign data_gnt = (grant == gnt_data);

	// steer the owner's address and write onto the array
	always_comb begin
		case (grant)
			gnt_load: begin
				mem_addr = load_addr;
				mem_we = load_we;
				mem_wdata = load_data;
			end
			gnt_data: begin
				mem_addr = data_req.addr;
				mem_we = data_req.write;
				mem_wdata = data_req.wdata;
			end
			gnt_fetch: begin
				mem_addr = fetch_req.addr;
				mem_we = fetch_req.write;
				mem_wdata = fetch_req.wdata;
			end
			default: begin
				mem_addr = '0;
				mem_we = 1'b0;
				mem_wdata = '0;
			end
		endcase
	end

	//////////////////////////////
	// unified word memory
	//////////////////////////////

	// async read for the pipeline
	assign rdata = mem[mem_addr];

	// loader sees its own address at any time, also after the halt
	assign load_rdata = mem[load_addr];

	always_ff @(posedge clk) begin
		if (mem_we)
			mem[mem_addr] <= mem_wdata;
	end

endmodule

//--- source/memory_stage.sv
`include "mips_settings.svh"

module memory_stage (
	input logic clk,
	input logic arst_n,
	input logic load_en,
	input mips_pkg::ex_mem_t ex_mem,
	output mips_pkg::mem_req_t data_req,
	input logic data_gnt,
	input logic [`MIPS_WORD_BITS-1:0] data_word,
	output mips_pkg::wb_t wb,
	output logic halted
);

	logic halted_q;
	logic active;

	// instructions behind the halt stay silent
	assign active = ex_mem.valid && !halted_q && !load_en;

	// data access at the alu word address
	always_comb begin
		data_req.valid = active && (ex_mem.mem_read || ex_mem.mem_write);
		data_req.write = active && ex_mem.mem_write;
		data_req.addr = ex_mem.alu_result[`MIPS_MEM_ADDR_BITS-1:0];
		data_req.wdata = ex_mem.store_data;
	end

	// write-back select, load data or alu result
	always_comb begin
		wb.en = active && ex_mem.reg_write && (!ex_mem.mem_read || data_gnt);
		wb.idx = ex_mem.dest;
		wb.data = ex_mem.mem_read ? data_word : ex_mem.alu_result;
	end

	// halt level, cleared only by loader or reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			halted_q <= 1'b0;
		else if (load_en)
			halted_q <= 1'b0;
		else if (ex_mem.valid && ex_mem.halt)
			halted_q <= 1'b1;
	end

	assign halted = halted_q;

endmodule

//--- source/execute_stage.sv
`include "mips_settings.svh"

module execute_stage (
	input logic clk,
	input logic arst_n,
	input logic load_en,
	input logic halted,
	input mips_pkg::id_ex_t id_ex,
	output logic redirect,
	output logic [`MIPS_MEM_ADDR_BITS-1:0] redirect_pc,
	output mips_pkg::ex_mem_t ex_mem
);
	import mips_pkg::*;

	logic [`MIPS_WORD_BITS-1:0] alu_b;
	logic [`MIPS_WORD_BITS-1:0] alu_y;
	logic [`MIPS_MEM_ADDR_BITS-1:0] branch_pc;
	logic taken;
	ex_mem_t nxt;
	ex_mem_t ex_mem_q;
	logic valid_q;

	//////////////////////////////
	// alu
	//////////////////////////////

	always_comb begin
		alu_b = id_ex.use_imm ? id_ex.imm : id_ex.rt_val;
		case (id_ex.alu_op)
			alu_add: alu_y = id_ex.rs_val + alu_b;
			alu_sub: alu_y = id_ex.rs_val - alu_b;
			alu_and: alu_y = id_ex.rs_val & alu_b;
			alu_or: alu_y = id_ex.rs_val | alu_b;
			// signed compare
			alu_slt: alu_y = {{(`MIPS_WORD_BITS-1){1'b0}},
				$signed(id_ex.rs_val) < $signed(alu_b)};
			default: alu_y = '0;
		endcase
	end

	// branch and jump resolve here
	assign branch_pc = id_ex.pc_plus1 + id_ex.imm[`MIPS_MEM_ADDR_BITS-1:0];
	assign taken = id_ex.valid && !halted &&
		(id_ex.is_jump || (id_ex.is_branch && id_ex.rs_val == id_ex.rt_val));
	assign redirect = taken;
	assign redirect_pc = id_ex.is_jump ? id_ex.jump_target : branch_pc;

	//////////////////////////////
	// ex/mem register
	//////////////////////////////

	always_comb begin
		nxt.valid = id_ex.valid;
		nxt.mem_read = id_ex.mem_read;
		nxt.mem_write = id_ex.mem_write;
		// control transfers never write a register
		nxt.reg_write = id_ex.reg_write && !id_ex.is_branch && !id_ex.is_jump;
		nxt.halt = id_ex.halt;
		nxt.dest = id_ex.dest;
		nxt.alu_result = alu_y;
		nxt.store_data = id_ex.rt_val;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid_q <= 1'b0;
		else if (load_en)
			valid_q <= 1'b0;
		else if (!halted)
			valid_q <= id_ex.valid;
	end

	always_ff @(posedge clk) begin
		if (!halted)
			ex_mem_q <= nxt;
	end

	always_comb begin
		ex_mem = ex_mem_q;
		ex_mem.valid = valid_q;
	end

endmodule

//--- source/decode_stage.sv
`include "mips_settings.svh"

module decode_stage (
	input logic clk,
	input logic arst_n,
	input logic load_en,
	input logic halted,
	input logic flush,
	input mips_pkg::if_id_t if_id,
	input mips_pkg::wb_t wb,
	input logic [`MIPS_REG_ADDR_BITS-1:0] dbg_reg_addr,
	output logic [`MIPS_WORD_BITS-1:0] dbg_reg_data,
	output mips_pkg::id_ex_t id_ex
);
	import mips_pkg::*;

	logic [`MIPS_WORD_BITS-1:0] regs [`MIPS_REG_COUNT];
	opcode_e opcode;
	funct_e funct;
	logic [`MIPS_REG_ADDR_BITS-1:0] rs;
	logic [`MIPS_REG_ADDR_BITS-1:0] rt;
	logic [`MIPS_REG_ADDR_BITS-1:0] rd;
	id_ex_t dec;
	id_ex_t id_ex_q;
	logic valid_q;

	// register read with write-through of the current write-back
	function automatic logic [`MIPS_WORD_BITS-1:0] read_reg(
		input logic [`MIPS_REG_ADDR_BITS-1:0] idx
	);
		if (idx == '0)
			return '0;
		else if (wb.en && wb.idx == idx)
			return wb.data;
		else
			return regs[idx];
	endfunction

	//////////////////////////////
	// field split
	//////////////////////////////

	assign opcode = opcode_e'(if_id.instr[31:26]);
	assign funct = funct_e'(if_id.instr[5:0]);
	assign rs = if_id.instr[25:21];
	assign rt = if_id.instr[20:16];
	assign rd = if_id.instr[15:11];

	//////////////////////////////
	// control decode
	//////////////////////////////

	always_comb begin
		dec = '0;
		dec.valid = if_id.valid;
		dec.alu_op = alu_add;
		dec.rs_val = read_reg(rs);
		dec.rt_val = read_reg(rt);
		dec.imm = {{(`MIPS_WORD_BITS-16){if_id.instr[15]}}, if_id.instr[15:0]};
		dec.pc_plus1 = if_id.pc_plus1;
		// instruction index is a word address already
		dec.jump_target = if_id.instr[`MIPS_MEM_ADDR_BITS-1:0];
		// i-type writes rt
		dec.dest = rt;
		case (opcode)
			op_special: begin
				dec.dest = rd;
				dec.reg_write = 1'b1;
				case (funct)
					fn_addu: dec.alu_op = alu_add;
					fn_subu: dec.alu_op = alu_sub;
					fn_and: dec.alu_op = alu_and;
					fn_or: dec.alu_op = alu_or;
					fn_slt: dec.alu_op = alu_slt;
					// unsupported function acts as nop
					default: dec.reg_write = 1'b0;
				endcase
			end
			op_addi: begin
				dec.use_imm = 1'b1;
				dec.reg_write = 1'b1;
			end
			op_lw: begin
				// address = rs + offset
				dec.use_imm = 1'b1;
				dec.mem_read = 1'b1;
				dec.reg_write = 1'b1;
			end
			op_sw: begin
				dec.use_imm = 1'b1;
				dec.mem_write = 1'b1;
			end
			op_beq: begin
				dec.alu_op = alu_sub;
				dec.is_branch = 1'b1;
			end
			op_j: dec.is_jump = 1'b1;
			op_halt: dec.halt = 1'b1;
			// unknown opcode, nop
			default: ;
		endcase
	end

	// debug port shares the read path
	always_comb begin
		dbg_reg_data = read_reg(dbg_reg_addr);
	end

	//////////////////////////////
	// register file and id/ex
	//////////////////////////////

	// r0 never written
	always_ff @(posedge clk) begin
		if (wb.en && wb.idx != '0)
			regs[wb.idx] <= wb.data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid_q <= 1'b0;
		else if (load_en)
			valid_q <= 1'b0;
		else if (!halted)
			valid_q <= if_id.valid && !flush;
	end

	always_ff @(posedge clk) begin
		if (!halted)
			id_ex_q <= dec;
	end

	always_comb begin
		id_ex = id_ex_q;
		id_ex.valid = valid_q;
	end

endmodule

//--- source/fetch_stage.sv
`include "mips_settings.svh"

module fetch_stage (
	input logic clk,
	input logic arst_n,
	input logic load_en,
	input logic halted,
	input logic redirect,
	input logic [`MIPS_MEM_ADDR_BITS-1:0] redirect_pc,
	output mips_pkg::mem_req_t fetch_req,
	input logic fetch_gnt,
	input logic [`MIPS_WORD_BITS-1:0] fetch_word,
	output mips_pkg::if_id_t if_id
);

	logic [`MIPS_MEM_ADDR_BITS-1:0] pc_q;
	logic [`MIPS_MEM_ADDR_BITS-1:0] pc_plus1;
	logic valid_q;
	logic [`MIPS_MEM_ADDR_BITS-1:0] pc_plus1_q;
	logic [`MIPS_WORD_BITS-1:0] instr_q;

	assign pc_plus1 = pc_q + 1'b1;

	// one read per cycle while running, never a write
	always_comb begin
		fetch_req.valid = !load_en && !halted;
		fetch_req.write = 1'b0;
		fetch_req.addr = pc_q;
		fetch_req.wdata = '0;
	end

	// pc and the valid bit of the fetch/decode register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= '0;
			valid_q <= 1'b0;
		end else if (load_en) begin
			pc_q <= '0;
			valid_q <= 1'b0;
		end else if (!halted) begin
			if (redirect) begin
				// word fetched this cycle is on the wrong path
				pc_q <= redirect_pc;
				valid_q <= 1'b0;
			end else if (fetch_gnt) begin
				pc_q <= pc_plus1;
				valid_q <= 1'b1;
			end else begin
				// memory busy with data, retry same pc
				valid_q <= 1'b0;
			end
		end
	end

	// instruction payload, only on a granted read
	always_ff @(posedge clk) begin
		if (fetch_gnt) begin
			pc_plus1_q <= pc_plus1;
			instr_q <= fetch_word;
		end
	end

	always_comb begin
		if_id.valid = valid_q;
		if_id.pc_plus1 = pc_plus1_q;
		if_id.instr = instr_q;
	end

endmodule

//--- source/mips_pkg.sv
`include "mips_settings.svh"

package mips_pkg;

	//////////////////////////////
	// encodings
	//////////////////////////////

	// primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j = 6'h02,
		op_beq = 6'h04,
		op_addi = 6'h08,
		op_lw = 6'h23,
		op_sw = 6'h2b,
		op_halt = 6'h3f
	} opcode_e;

	// function field of r-type, bits 5:0
	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and = 6'h24,
		fn_or = 6'h25,
		fn_slt = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_e;

	// current owner of the unified memory
	typedef enum logic [1:0] {
		gnt_none,
		gnt_fetch,
		gnt_data,
		gnt_load
	} grant_e;

	//////////////////////////////
	// buses and pipeline registers
	//////////////////////////////

	typedef struct packed {
		logic valid;
		logic write;
		logic [`MIPS_MEM_ADDR_BITS-1:0] addr;
		logic [`MIPS_WORD_BITS-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic valid;
		logic [`MIPS_MEM_ADDR_BITS-1:0] pc_plus1;
		logic [`MIPS_WORD_BITS-1:0] instr;
	} if_id_t;

	typedef struct packed {
		logic valid;
		alu_op_e alu_op;
		logic use_imm;
		// control flags
		logic is_branch;
		logic is_jump;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		logic halt;
		// operands
		logic [`MIPS_REG_ADDR_BITS-1:0] dest;
		logic [`MIPS_WORD_BITS-1:0] rs_val;
		logic [`MIPS_WORD_BITS-1:0] rt_val;
		logic [`MIPS_WORD_BITS-1:0] imm;
		logic [`MIPS_MEM_ADDR_BITS-1:0] pc_plus1;
		logic [`MIPS_MEM_ADDR_BITS-1:0] jump_target;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		logic halt;
		logic [`MIPS_REG_ADDR_BITS-1:0] dest;
		logic [`MIPS_WORD_BITS-1:0] alu_result;
		logic [`MIPS_WORD_BITS-1:0] store_data;
	} ex_mem_t;

	// register file write port
	typedef struct packed {
		logic en;
		logic [`MIPS_REG_ADDR_BITS-1:0] idx;
		logic [`MIPS_WORD_BITS-1:0] data;
	} wb_t;

endpackage

//--- source/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

//////////////////////////////
// datapath and memory sizes
//////////////////////////////

// data and instruction width
`define MIPS_WORD_BITS 32

// unified memory is word addressed
`define MIPS_MEM_ADDR_BITS 8
`define MIPS_MEM_WORDS 256

// register file
`define MIPS_REG_ADDR_BITS 5
`define MIPS_REG_COUNT 32

`endif
